//--- hdl/rs_pkg.sv
// Shared types for the issue-to-execute slice.
// Tag 0 means "value present"; only tags 1 to 7 name a pending producer.
// Operand and result words are 32 bits wide.

package rs_pkg;

    typedef logic [2:0] rob_tag_t;
    typedef logic [31:0] word_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_slt,
        // used by branches
        alu_cmp
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt
    } branch_type_t;

    // instruction as it leaves the issue stage
    typedef struct packed {
        alu_op_t      alu_op;
        branch_type_t branch_type;
        rob_tag_t     rob_entry;
        rob_tag_t     q_j;
        rob_tag_t     q_k;
        word_t        v_j;
        word_t        v_k;
    } issue_t;

    typedef struct packed {
        logic   busy;
        issue_t inst;
    } rs_data_t;

    // station view seen by the selector
    typedef struct packed {
        alu_op_t      alu_op;
        branch_type_t branch_type;
        rob_tag_t     rob_entry;
        word_t        op_a;
        word_t        op_b;
        logic         valid_operands;
    } rs_out_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t dest_rob_entry;
        word_t    result;
        logic     taken;
    } cdb_packet_t;

endpackage

//--- hdl/rs_entry.sv
// One reservation station.
// Captures a CDB result only for a nonzero pending tag and a valid packet.
// valid_operands lags the last operand capture by one cycle.

module rs_entry (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                load,
    input  rs_pkg::rs_data_t    load_data,
    input  rs_pkg::cdb_packet_t cdb,
    output logic                busy,
    output rs_pkg::rs_out_t     out
);
    import rs_pkg::*;

    logic         busy_q;
    rob_tag_t     q_j;
    rob_tag_t     q_k;
    logic         valid_operands;
    alu_op_t      alu_op;
    branch_type_t branch_type;
    rob_tag_t     rob_entry;
    word_t        v_j;
    word_t        v_k;
    logic         hit_j;
    logic         hit_k;

    // snoop matches for operands still waiting
    assign hit_j = cdb.valid && (q_j != '0) && (cdb.dest_rob_entry == q_j);
    assign hit_k = cdb.valid && (q_k != '0) && (cdb.dest_rob_entry == q_k);

    // clear wins over load, load wins over snoop
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            busy_q <= 1'b0;
            q_j    <= '0;
            q_k    <= '0;
        end else if (load) begin
            busy_q <= load_data.busy;
            q_j    <= load_data.inst.q_j;
            q_k    <= load_data.inst.q_k;
        end else begin
            if (hit_j) begin
                q_j <= '0;
            end
            if (hit_k) begin
                q_k <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            alu_op      <= load_data.inst.alu_op;
            branch_type <= load_data.inst.branch_type;
            rob_entry   <= load_data.inst.rob_entry;
            v_j         <= load_data.inst.v_j;
            v_k         <= load_data.inst.v_k;
        end else begin
            if (hit_j) begin
                v_j <= cdb.result;
            end
            if (hit_k) begin
                v_k <= cdb.result;
            end
        end
    end

    // one cycle late, lines up with the selector
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            valid_operands <= 1'b0;
        end else begin
            valid_operands <= busy_q && (q_j == '0) && (q_k == '0);
        end
    end

    assign busy = busy_q;

    always_comb begin
        out.alu_op         = alu_op;
        out.branch_type    = branch_type;
        out.rob_entry      = rob_entry;
        out.op_a           = v_j;
        out.op_b           = v_k;
        out.valid_operands = valid_operands;
    end

endmodule

//--- hdl/rs_bank.sv
// Bank of num_stations reservation stations.
// A load is dropped in any cycle with flush high.

module rs_bank #(
    parameter int num_stations = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                load_valid,
    input  logic [$clog2(num_stations)-1:0]     load_station,
    input  rs_pkg::rs_data_t                    load_data,
    input  logic [num_stations-1:0]             consumed,
    input  rs_pkg::cdb_packet_t                 cdb,
    output logic [num_stations-1:0]             busy,
    output rs_pkg::rs_out_t                     station_out [num_stations]
);
    localparam int sel_w = $clog2(num_stations);

    logic [num_stations-1:0] load;
    logic [num_stations-1:0] clear;

    for (genvar i = 0; i < num_stations; i++) begin : g_station
        // decoded load strobe for this station
        assign load[i]  = load_valid && !flush && (load_station == sel_w'(i));
        assign clear[i] = flush || consumed[i];

        rs_entry i_entry (
            .clk       (clk),
            .reset     (reset),
            .clear     (clear[i]),
            .load      (load[i]),
            .load_data (load_data),
            .cdb       (cdb),
            .busy      (busy[i]),
            .out       (station_out[i])
        );
    end

endmodule

//--- hdl/rs_dispatch.sv
// Places an issued instruction into the lowest free station.
// stall depends on the busy bits only, never on issue_valid.
// Forwards a same-cycle CDB result into the incoming operands.

module rs_dispatch #(
    parameter int num_stations = 4
) (
    input  logic                            issue_valid,
    input  rs_pkg::issue_t                  issue,
    input  logic [num_stations-1:0]         busy,
    input  rs_pkg::cdb_packet_t             cdb,
    output logic                            stall,
    output logic                            load_valid,
    output logic [$clog2(num_stations)-1:0] load_station,
    output rs_pkg::rs_data_t                load_data
);
    localparam int sel_w = $clog2(num_stations);

    assign stall      = &busy;
    assign load_valid = issue_valid && !stall;

    // scan downward so the lowest free index wins
    always_comb begin
        load_station = '0;
        for (int i = num_stations - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                load_station = sel_w'(i);
            end
        end
    end

    // the entry would miss this broadcast, so take it here
    always_comb begin
        load_data.busy = 1'b1;
        load_data.inst = issue;
        if (cdb.valid && (issue.q_j != '0) && (cdb.dest_rob_entry == issue.q_j)) begin
            load_data.inst.q_j = '0;
            load_data.inst.v_j = cdb.result;
        end
        if (cdb.valid && (issue.q_k != '0) && (cdb.dest_rob_entry == issue.q_k)) begin
            load_data.inst.q_k = '0;
            load_data.inst.v_k = cdb.result;
        end
    end

endmodule

//--- hdl/fu_select.sv
// Grants the lowest-numbered ready station to the single ALU.
// consumed is combinational and frees the station at the next edge,
// the same edge that captures alu_in.

module fu_select #(
    parameter int num_stations = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic [num_stations-1:0] busy,
    input  rs_pkg::rs_out_t         station_out [num_stations],
    output logic [num_stations-1:0] consumed,
    output logic                    alu_in_valid,
    output rs_pkg::rs_out_t         alu_in
);
    localparam int sel_w = $clog2(num_stations);

    logic [num_stations-1:0] ready;
    logic [sel_w-1:0]        grant_idx;
    logic                    grant_any;

    always_comb begin
        for (int i = 0; i < num_stations; i++) begin
            ready[i] = busy[i] && station_out[i].valid_operands;
        end
    end

    // fixed priority, lowest index first
    always_comb begin
        grant_idx = '0;
        consumed  = '0;
        for (int i = num_stations - 1; i >= 0; i--) begin
            if (ready[i]) begin
                grant_idx = sel_w'(i);
            end
        end
        grant_any = |ready;
        if (grant_any) begin
            consumed[grant_idx] = 1'b1;
        end
    end

    // ALU input stage
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            alu_in_valid <= 1'b0;
        end else begin
            alu_in_valid <= grant_any;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_any) begin
            alu_in <= station_out[grant_idx];
        end
    end

endmodule

//--- hdl/alu_unit.sv
// Single-cycle integer ALU that drives the CDB register.
// Branches return result 0 with taken from the compare.
// cmp with no branch type returns op_a - op_b.

module alu_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                alu_in_valid,
    input  rs_pkg::rs_out_t     alu_in,
    output rs_pkg::cdb_packet_t cdb
);
    import rs_pkg::*;

    word_t    a;
    word_t    b;
    word_t    result;
    logic     taken;
    logic     cdb_valid;
    rob_tag_t cdb_dest;
    word_t    cdb_result;
    logic     cdb_taken;

    assign a = alu_in.op_a;
    assign b = alu_in.op_b;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        if (alu_in.branch_type == br_none) begin
            case (alu_in.alu_op)
                alu_add: result = a + b;
                alu_sub: result = a - b;
                alu_and: result = a & b;
                alu_or:  result = a | b;
                alu_xor: result = a ^ b;
                // shift amount from low 5 bits only
                alu_sll: result = a << b[4:0];
                alu_slt: result = {31'b0, $signed(a) < $signed(b)};
                alu_cmp: result = a - b;
            endcase
        end else begin
            case (alu_in.branch_type)
                br_beq:  taken = (a == b);
                br_bne:  taken = (a != b);
                br_blt:  taken = ($signed(a) < $signed(b));
                default: taken = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_in_valid) begin
            cdb_dest   <= alu_in.rob_entry;
            cdb_result <= result;
            cdb_taken  <= taken;
        end
    end

    always_comb begin
        cdb.valid          = cdb_valid;
        cdb.dest_rob_entry = cdb_dest;
        cdb.result         = cdb_result;
        cdb.taken          = cdb_taken;
    end

endmodule

//--- hdl/rs_top.sv
// Issue-to-execute slice: dispatch, station bank, select and one ALU.
// Hold issue while stall is high. The CDB feeds back into dispatch and
// the bank. num_stations may be 2 to 8.

module rs_top #(
    parameter int num_stations = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                issue_valid,
    input  rs_pkg::issue_t      issue,
    output logic                stall,
    output rs_pkg::cdb_packet_t cdb
);
    import rs_pkg::*;

    logic                            load_valid;
    logic [$clog2(num_stations)-1:0] load_station;
    rs_data_t                        load_data;
    logic [num_stations-1:0]         busy;
    logic [num_stations-1:0]         consumed;
    rs_out_t                         station_out [num_stations];
    logic                            alu_in_valid;
    rs_out_t                         alu_in;

    rs_dispatch #(.num_stations(num_stations)) i_dispatch (
        .issue_valid  (issue_valid),
        .issue        (issue),
        .busy         (busy),
        .cdb          (cdb),
        .stall        (stall),
        .load_valid   (load_valid),
        .load_station (load_station),
        .load_data    (load_data)
    );

    rs_bank #(.num_stations(num_stations)) i_bank (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .load_valid   (load_valid),
        .load_station (load_station),
        .load_data    (load_data),
        .consumed     (consumed),
        .cdb          (cdb),
        .busy         (busy),
        .station_out  (station_out)
    );

    fu_select #(.num_stations(num_stations)) i_select (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .busy         (busy),
        .station_out  (station_out),
        .consumed     (consumed),
        .alu_in_valid (alu_in_valid),
        .alu_in       (alu_in)
    );

    alu_unit i_alu (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .alu_in_valid (alu_in_valid),
        .alu_in       (alu_in),
        .cdb          (cdb)
    );

endmodule

//--- bench/rs_checker.sv
// Scoreboard for the issue-to-execute slice, indexed by reorder-buffer tag.
// Operand values resolve from issue, from a same-cycle CDB or a later broadcast.
// A flush drops every pending expectation. No result may arrive sooner
// than four edges after its instruction was accepted.

module rs_checker #(
    parameter int num_stations = 4
) (
    input logic                clk,
    input logic                reset,
    input logic                flush,
    input logic                issue_valid,
    input rs_pkg::issue_t      issue,
    input logic                stall,
    input rs_pkg::cdb_packet_t cdb
);
    timeunit 1ns;
    timeprecision 100ps;
    import rs_pkg::*;

    // accept, operands ready, ALU input, CDB register, then sampled here
    localparam int min_latency = 4;

    int         errors = 0;
    int         accepted = 0;
    int         completed = 0;
    int         cycle = 0;
    int         issue_cycle [8];
    issue_t     sb [8];
    logic [7:0] pend;
    logic [7:0] rdy_j;
    logic [7:0] rdy_k;

    // expected {taken, result}
    function automatic logic [32:0] ref_calc(alu_op_t op, branch_type_t br, word_t a, word_t b);
        word_t r;
        logic  tk;
        r  = 32'h0;
        tk = 1'b0;
        case (br)
            br_beq: tk = (a == b);
            br_bne: tk = (a != b);
            br_blt: tk = ($signed(a) < $signed(b));
            default: begin
                case (op)
                    alu_add: r = a + b;
                    alu_sub: r = a - b;
                    alu_and: r = a & b;
                    alu_or:  r = a | b;
                    alu_xor: r = a ^ b;
                    alu_sll: r = a << b[4:0];
                    alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: r = a - b;
                endcase
            end
        endcase
        return {tk, r};
    endfunction

    always @(posedge clk) begin
        logic [32:0] exp;
        int          t;
        cycle++;
        if (reset) begin
            pend = '0;
        end else begin
            // every busy station holds an accepted instruction not yet broadcast
            if (stall && $countones(pend) < num_stations) begin
                errors++;
                $display("Error at %0t: stall high with only %0d instructions pending",
                         $time, $countones(pend));
            end
            if (cdb.valid) begin
                t = cdb.dest_rob_entry;
                if (!pend[t]) begin
                    errors++;
                    $display("Error at %0t: CDB packet for tag %0d with no pending instruction",
                             $time, t);
                end else if (!(rdy_j[t] && rdy_k[t])) begin
                    errors++;
                    $display("Error at %0t: tag %0d completed before its producers", $time, t);
                    pend[t] = 1'b0;
                end else begin
                    if (cycle - issue_cycle[t] < min_latency) begin
                        errors++;
                        $display("Error at %0t: tag %0d completed %0d cycles after issue, too early",
                                 $time, t, cycle - issue_cycle[t]);
                    end
                    exp = ref_calc(sb[t].alu_op, sb[t].branch_type, sb[t].v_j, sb[t].v_k);
                    if (cdb.result !== exp[31:0]) begin
                        errors++;
                        $display("Mismatch at %0t: cdb.result tag %0d expected %h got %h",
                                 $time, t, exp[31:0], cdb.result);
                    end
                    if (cdb.taken !== exp[32]) begin
                        errors++;
                        $display("Mismatch at %0t: cdb.taken tag %0d expected %b got %b",
                                 $time, t, exp[32], cdb.taken);
                    end
                    completed++;
                    pend[t] = 1'b0;
                end
                // wake up waiting consumers
                for (int u = 1; u < 8; u++) begin
                    if (pend[u] && !rdy_j[u] && sb[u].q_j == cdb.dest_rob_entry) begin
                        sb[u].v_j = cdb.result;
                        rdy_j[u]  = 1'b1;
                    end
                    if (pend[u] && !rdy_k[u] && sb[u].q_k == cdb.dest_rob_entry) begin
                        sb[u].v_k = cdb.result;
                        rdy_k[u]  = 1'b1;
                    end
                end
            end
            if (flush) begin
                pend = '0;
            end else if (issue_valid && !stall) begin
                t = issue.rob_entry;
                if (pend[t]) begin
                    errors++;
                    $display("Error at %0t: tag %0d issued while still pending", $time, t);
                end
                sb[t]          = issue;
                pend[t]        = 1'b1;
                issue_cycle[t] = cycle;
                rdy_j[t]       = (issue.q_j == 3'd0);
                rdy_k[t]       = (issue.q_k == 3'd0);
                // producer broadcasting in the accept cycle
                if (!rdy_j[t] && cdb.valid && cdb.dest_rob_entry == issue.q_j) begin
                    sb[t].v_j = cdb.result;
                    rdy_j[t]  = 1'b1;
                end
                if (!rdy_k[t] && cdb.valid && cdb.dest_rob_entry == issue.q_k) begin
                    sb[t].v_k = cdb.result;
                    rdy_k[t]  = 1'b1;
                end
                accepted++;
            end
        end
    end

endmodule

//--- bench/rs_tb.sv
// Testbench for rs_top with four stations. Plays the reorder buffer.
// Hands out tags 1 to 7 and supplies values of producers already finished.
// Inputs change 1 ns after the rising edge.

module rs_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rs_pkg::*;

    localparam int num_stations = 4;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        issue_valid;
    issue_t      issue;
    logic        stall;
    cdb_packet_t cdb;
    integer      seed = 32'h3bd8_dd53;
    logic [7:0]  in_flight;
    word_t       result_by_tag [8];
    logic        timed_out;
    int          stall_cycles;
    int          bench_errors;
    rob_tag_t    ta;
    rob_tag_t    tb;
    word_t       pair_a [5] = '{32'd5, 32'd5, -32'sd3, 32'd4, -32'sd2};
    word_t       pair_b [5] = '{32'd5, 32'd7, 32'd4, -32'sd3, -32'sd2};

    always #5 clk = ~clk;

    rs_top #(.num_stations(num_stations)) i_dut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .stall       (stall),
        .cdb         (cdb)
    );

    rs_checker #(.num_stations(num_stations)) i_chk (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .stall       (stall),
        .cdb         (cdb)
    );

    // retire tags as their results leave the CDB
    always @(posedge clk) begin
        if (reset || flush) begin
            in_flight = '0;
        end else if (cdb.valid) begin
            in_flight[cdb.dest_rob_entry]     = 1'b0;
            result_by_tag[cdb.dest_rob_entry] = cdb.result;
        end
        if (stall) begin
            stall_cycles++;
        end
    end

    function automatic rob_tag_t pick_pending();
        rob_tag_t t;
        t = 3'd0;
        for (int i = 0; i < 16 && t == 3'd0 && in_flight != 8'h0; i++) begin
            t = 3'($random(seed));
            if (!in_flight[t]) begin
                t = 3'd0;
            end
        end
        return t;
    endfunction

    task automatic alloc_tag(output rob_tag_t t);
        t = 3'd0;
        for (int n = 0; n < 100 && t == 3'd0 && !timed_out; n++) begin
            for (int i = 7; i >= 1; i--) begin
                if (!in_flight[i]) begin
                    t = 3'(i);
                end
            end
            if (t == 3'd0) begin
                @(posedge clk);
                #1;
            end
        end
        if (t == 3'd0 && !timed_out) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: no reorder-buffer tag became free", $time);
        end
    endtask

    task automatic issue_one(alu_op_t op, branch_type_t br, rob_tag_t qj, rob_tag_t qk,
                             word_t vj, word_t vk, output rob_tag_t t);
        logic     take;
        rob_tag_t src_j;
        rob_tag_t src_k;
        word_t    val_j;
        word_t    val_k;
        take  = 1'b0;
        src_j = qj;
        src_k = qk;
        val_j = vj;
        val_k = vk;
        alloc_tag(t);
        for (int n = 0; n < 100 && !take && !timed_out; n++) begin
            // a producer that already finished hands over its value
            if (src_j != 3'd0 && !in_flight[src_j]) begin
                val_j = result_by_tag[src_j];
                src_j = 3'd0;
            end
            if (src_k != 3'd0 && !in_flight[src_k]) begin
                val_k = result_by_tag[src_k];
                src_k = 3'd0;
            end
            issue       = '{op, br, t, src_j, src_k, val_j, val_k};
            issue_valid = 1'b1;
            take        = !stall;
            @(posedge clk);
            #1;
        end
        issue_valid = 1'b0;
        if (take) begin
            in_flight[t] = 1'b1;
        end else if (!timed_out) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: instruction held by stall for too long", $time);
        end
    endtask

    task automatic wait_drain();
        for (int n = 0; n < 300 && in_flight != 8'h0 && !timed_out; n++) begin
            @(posedge clk);
            #1;
        end
        if (in_flight != 8'h0 && !timed_out) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: pending instructions never completed", $time);
        end
    endtask

    task automatic wait_cdb(rob_tag_t t);
        for (int n = 0; n < 50 && !(cdb.valid && cdb.dest_rob_entry == t) && !timed_out; n++) begin
            @(posedge clk);
            #1;
        end
        if (!(cdb.valid && cdb.dest_rob_entry == t) && !timed_out) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: tag %0d never appeared on the CDB", $time, t);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        in_flight    = '0;
        timed_out    = 1'b0;
        stall_cycles = 0;
        bench_errors = 0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        // independent arithmetic over every alu_op
        for (int i = 0; i < 32; i++) begin
            issue_one(alu_op_t'(3'(i)), br_none, 3'd0, 3'd0, $random(seed), $random(seed), ta);
        end
        wait_drain();
        // random dependency chains
        for (int i = 0; i < 40; i++) begin
            issue_one(alu_op_t'(3'($random(seed))), br_none, pick_pending(),
                      ($random(seed) & 1) ? pick_pending() : 3'd0,
                      $random(seed), $random(seed), ta);
        end
        wait_drain();
        // issue in the same cycle as the producer's broadcast
        for (int i = 0; i < 4; i++) begin
            issue_one(alu_add, br_none, 3'd0, 3'd0, $random(seed), $random(seed), ta);
            wait_cdb(ta);
            issue_one(alu_xor, br_none, ta, 3'd0, 32'h0, $random(seed), tb);
        end
        wait_drain();
        for (int br = 1; br < 4; br++) begin
            for (int p = 0; p < 5; p++) begin
                issue_one(alu_cmp, branch_type_t'(2'(br)), 3'd0, 3'd0, pair_a[p], pair_b[p], ta);
            end
        end
        wait_drain();
        // fill the bank behind a two-deep chain
        stall_cycles = 0;
        issue_one(alu_add, br_none, 3'd0, 3'd0, $random(seed), $random(seed), ta);
        issue_one(alu_sub, br_none, ta, 3'd0, 32'h0, $random(seed), tb);
        for (int i = 0; i < 5; i++) begin
            issue_one(alu_op_t'(3'(i)), br_none, tb, 3'd0, 32'h0, $random(seed), ta);
        end
        if (stall_cycles == 0 && !timed_out) begin
            bench_errors++;
            $display("Error at %0t: stall never rose with the bank full", $time);
        end
        wait_drain();
        // flush with a chain still waiting
        issue_one(alu_add, br_none, 3'd0, 3'd0, $random(seed), $random(seed), ta);
        issue_one(alu_or, br_none, ta, 3'd0, 32'h0, $random(seed), tb);
        issue_one(alu_sll, br_none, tb, 3'd0, 32'h0, $random(seed), ta);
        flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        for (int i = 0; i < 6; i++) begin
            issue_one(alu_op_t'(3'(i)), br_none, 3'd0, 3'd0, $random(seed), $random(seed), ta);
        end
        wait_drain();
        repeat (5) @(posedge clk);
        $display("%0d accepted, %0d done, %0d checker errors, %0d bench errors, %0d timeouts",
                 i_chk.accepted, i_chk.completed, i_chk.errors, bench_errors, timed_out);
        if (timed_out || bench_errors != 0 || i_chk.errors != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/rs_pkg.sv
hdl/rs_entry.sv
hdl/rs_bank.sv
hdl/rs_dispatch.sv
hdl/fu_select.sv
hdl/alu_unit.sv
hdl/rs_top.sv
bench/rs_checker.sv
bench/rs_tb.sv
